//--- sim/link_rx_testdata.txt
# T name, D hex nibbles in send order, E end of packet, S end of packet held by a full output
# O raw wire mask, R always|never|random, X expected 72-bit packet, Q acks seen with no input
T reset_ack
Q 1
T short_packet
X 00000000D6A9F0E3C5
D 5C3E0F9A6D
E
T long_packet
X F0AD695C3E810F4B72
D 27B4F018E3C596DA0F
E
T frame_error
D 123456
E
D 0123456789AB
E
X 00000000CB73901248
D 84210937BC
E
T out_of_band
D 012
O 07
D 34
E
X 00000000DC01456789
D 98765410CD
E
T back_pressure
R never
X 00000000BCDEF01234
D 43210FEDCB
E
X 00000000A5B4C3D2E1
D 1E2D3C4B5A
S
T random_ready
R random
X 000000009321EEFF0C
D C0FFEE1239
E
X 169693C3C0F0F5A5A6
D 6A5A5F0F0C3C396961
E
X 00000000F012345678
D 876543210F
E

//--- sources.f
rtl/link_pkg.sv
rtl/pkt_pkg.sv
rtl/symbol_decoder.sv
rtl/frame_assembler.sv
rtl/packet_out_reg.sv
rtl/spinnaker_link_rx.sv
sim/tb_clock_gen.sv
sim/link_rx_tb.sv

//--- run.sh
#!/bin/sh
# verilator build and run of the link receiver testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module link_rx_tb -f sources.f -o link_rx_sim \
  || { echo "build failed"; exit 1; }

out="$(./obj_dir/link_rx_sim)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation finished: PASS" \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

//--- sim/link_rx_tb.sv
// link receiver testbench
`timescale 1ns/1ps

module link_rx_tb import link_pkg::*, pkt_pkg::*; ();

  localparam string       DATA_FILE    = "sim/link_rx_testdata.txt";
  localparam int          RESET_WAIT   = 64;   // cycles for reset to drop
  localparam int          ACK_WAIT     = 50;
  localparam int          STALL_HOLD   = 20;   // ack must stay quiet this long
  localparam int          STALL_WAIT   = 200;
  localparam int          DRAIN_WAIT   = 400;
  localparam int          QUIET_CYCLES = 20;
  localparam logic [31:0] SEED         = 32'h27c2_7fc3;

  logic      CLK_IN;
  logic      RESET_IN;
  code_t     sl_data_2of7;
  logic      sl_ack;
  pkt_data_t pkt_data;
  logic      pkt_vld;
  logic      pkt_rdy;

  int        rdy_mode = 0;       // 0 always, 1 never, 2 random
  logic      last_ack;           // sl_ack after last seen toggle
  pkt_data_t exp_q[$];           // packets still to come, oldest first
  int        errors = 0;
  int        tests = 0;
  int        failed_tests = 0;
  int        test_err_base = 0;
  string     test_name = "";
  bit        test_open = 1'b0;

  tb_clock_gen clk_gen (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN)
  );

  spinnaker_link_rx dut (
    .CLK_IN       (CLK_IN),
    .RESET_IN     (RESET_IN),
    .sl_data_2of7 (sl_data_2of7),
    .sl_ack       (sl_ack),
    .pkt_data     (pkt_data),
    .pkt_vld      (pkt_vld),
    .pkt_rdy      (pkt_rdy)
  );

  // ------------------------------
  // consumer side
  // ------------------------------
  initial begin : rdy_drive
    pkt_rdy = 1'b0;
    void'($urandom(SEED));  // one seed for the whole run
    forever begin
      @(posedge CLK_IN);
      case (rdy_mode)
        0:       pkt_rdy <= 1'b1;
        1:       pkt_rdy <= 1'b0;
        default: pkt_rdy <= ($urandom % 2) == 1;
      endcase
    end
  end

  // vld and rdy at the falling edge mean a transfer on the next rising one
  always @(negedge CLK_IN) begin
    if (!RESET_IN && pkt_vld && pkt_rdy) begin
      assert (exp_q.size() > 0) else begin
        $display("unexpected packet %h at %0t with none expected", pkt_data, $time);
        errors++;
      end
      if (exp_q.size() > 0) begin
        assert (pkt_data === exp_q[0]) else begin
          $display("ERR t=%0t pkt_data got %h expected %h", $time, pkt_data, exp_q[0]);
          errors++;
        end
        void'(exp_q.pop_front());
      end
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------
  // 2-of-7 code, groups 6..4 with 3..0, then the ring of 3..0
  function automatic code_t nibble_code(input nibble_t n);
    code_t c;
    int    v;
    c = '0;
    v = int'(n);
    if (v < 12) begin
      c[4 + v / 4] = 1'b1;
      c[v % 4]     = 1'b1;
    end else begin
      c[v - 12]       = 1'b1;
      c[(v - 11) % 4] = 1'b1;  // 15 wraps to wire 0
    end
    return c;
  endfunction

  function automatic nibble_t hex_nibble(input byte c);
    if (c >= "0" && c <= "9") return nibble_t'(c - 8'h30);
    if (c >= "A" && c <= "F") return nibble_t'(c - 8'h37);
    if (c >= "a" && c <= "f") return nibble_t'(c - 8'h57);
    $display("bad hex digit '%c' in test data", c);
    errors++;
    return '0;
  endfunction

  function automatic pkt_data_t hex_to_bits(input string s);
    pkt_data_t v;
    int        i;
    v = '0;
    for (i = 0; i < s.len(); i++) begin
      v = {v[PKT_BITS-5:0], hex_nibble(s[i])};
    end
    return v;
  endfunction

  // drop line end and trailing blanks
  function automatic string trim_line(input string s);
    int last;
    last = s.len() - 1;
    while (last >= 0 && (s[last] == 8'h0a || s[last] == 8'h0d || s[last] == 8'h20)) begin
      last--;
    end
    return (last < 0) ? "" : s.substr(0, last);
  endfunction

  task automatic wait_reset_release();
    int i;
    for (i = 0; i < RESET_WAIT && RESET_IN !== 1'b0; i++) begin
      @(negedge CLK_IN);
    end
    assert (RESET_IN === 1'b0) else begin
      $display("reset still high after %0d cycles", RESET_WAIT);
      errors++;
    end
  endtask

  task automatic send_code(input code_t c);
    @(posedge CLK_IN);
    sl_data_2of7 <= sl_data_2of7 ^ c;  // flip the symbol's wires
  endtask

  task automatic wait_ack(input int limit, input string what);
    int i;
    bit seen;
    seen = 1'b0;
    for (i = 0; i < limit && !seen; i++) begin
      @(negedge CLK_IN);
      if (sl_ack !== last_ack) begin
        seen     = 1'b1;
        last_ack = sl_ack;
      end
    end
    assert (seen) else begin
      $display("no ack for %s within %0d cycles at %0t", what, limit, $time);
      errors++;
    end
  endtask

  // eop behind a full output, ack must wait until the register drains
  task automatic send_stalled_eop();
    int i;
    bit early;
    early = 1'b0;
    send_code(EOP_CODE);
    for (i = 0; i < STALL_HOLD && !early; i++) begin
      @(negedge CLK_IN);
      early = (sl_ack !== last_ack);
    end
    assert (!early) else begin
      $display("ERR t=%0t sl_ack got %b expected %b", $time, sl_ack, last_ack);
      errors++;
      last_ack = sl_ack;
    end
    rdy_mode = 0;  // consumer wakes up
    if (!early) begin
      wait_ack(STALL_WAIT, "held end of packet");
    end
  endtask

  task automatic check_quiet_acks(input int expected);
    int   i;
    int   toggles;
    logic prev;
    toggles = 0;
    prev    = last_ack;
    for (i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge CLK_IN);
      if (sl_ack !== prev) begin
        toggles++;
      end
      prev = sl_ack;
      assert (pkt_vld === 1'b0) else begin
        $display("ERR t=%0t pkt_vld got %b expected 0", $time, pkt_vld);
        errors++;
      end
    end
    last_ack = prev;
    assert (toggles == expected) else begin
      $display("ERR t=%0t sl_ack toggles got %0d expected %0d", $time, toggles, expected);
      errors++;
    end
  endtask

  task automatic close_test();
    int i;
    if (test_open) begin
      for (i = 0; i < DRAIN_WAIT && exp_q.size() > 0; i++) begin
        @(negedge CLK_IN);
      end
      assert (exp_q.size() == 0) else begin
        $display("%0d expected packets never arrived in %s", exp_q.size(), test_name);
        errors++;
        exp_q.delete();
      end
      tests++;
      if (errors != test_err_base) begin
        failed_tests++;
      end
      $display("test %-16s %s, %0d errors", test_name,
               (errors == test_err_base) ? "ok" : "FAILED", errors - test_err_base);
      test_open = 1'b0;
    end
  endtask

  // ------------------------------
  // command decoding
  // ------------------------------
  task automatic run_command(input string line);
    byte   cmd;
    string arg;
    int    i;
    if (line.len() == 0 || line[0] == "#") return;
    cmd = line[0];
    arg = (line.len() > 2) ? line.substr(2, line.len() - 1) : "";
    case (cmd)
      "T": begin
        close_test();
        test_name     = arg;
        test_err_base = errors;
        test_open     = 1'b1;
      end
      "D": begin
        for (i = 0; i < arg.len(); i++) begin
          send_code(nibble_code(hex_nibble(arg[i])));
          wait_ack(ACK_WAIT, "data symbol");
        end
      end
      "E": begin
        send_code(EOP_CODE);
        wait_ack(ACK_WAIT, "end of packet");
      end
      "S": send_stalled_eop();
      "O": begin
        send_code(code_t'(hex_to_bits(arg)));  // raw wire mask
        wait_ack(ACK_WAIT, "out-of-band symbol");
      end
      "R": begin
        if (arg == "always") rdy_mode = 0;
        else if (arg == "never") rdy_mode = 1;
        else if (arg == "random") rdy_mode = 2;
        else begin
          $display("unknown ready mode '%s' in test data", arg);
          errors++;
        end
      end
      "X": exp_q.push_back(hex_to_bits(arg));
      "Q": check_quiet_acks(arg.atoi());
      default: begin
        $display("unknown command in test data: %s", line);
        errors++;
      end
    endcase
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin : main
    int    fd;
    string line;
    sl_data_2of7 = '0;
    last_ack     = 1'b0;
    wait_reset_release();
    fd = $fopen(DATA_FILE, "r");
    assert (fd != 0) else begin
      $display("cannot open test data %s", DATA_FILE);
      errors++;
    end
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          run_command(trim_line(line));
        end
      end
      $fclose(fd);
    end
    close_test();
    $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0 && tests > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- sim/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
  output logic CLK_IN,
  output logic RESET_IN
);

  localparam realtime HALF_PERIOD  = 2.0ns;  // 4 ns clock
  localparam int      RESET_CYCLES = 16;

  initial begin
    CLK_IN = 1'b0;
    forever #(HALF_PERIOD) CLK_IN = ~CLK_IN;
  end

  // reset held over the first edges
  initial begin
    RESET_IN = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK_IN);
    RESET_IN <= 1'b0;
  end

endmodule

//--- rtl/spinnaker_link_rx.sv
// spinnaker link receiver
// top level
`timescale 1ns/1ps

module spinnaker_link_rx import link_pkg::*, pkt_pkg::*; (
  input  logic      CLK_IN,
  input  logic      RESET_IN,
  input  code_t     sl_data_2of7,  // link wires from sender
  output logic      sl_ack,        // ack back to sender
  output pkt_data_t pkt_data,
  output logic      pkt_vld,
  input  logic      pkt_rdy
);

  sym_t      sym;      // decoded symbol
  logic      consume;  // symbol accepted
  pkt_beat_t beat;     // finished packet
  logic      busy;     // output register full and stalled

  // ------------------------------
  // decode
  // ------------------------------
  symbol_decoder u_dec (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .wires    (sl_data_2of7),
    .consume  (consume),
    .sym      (sym)
  );

  // frame fsm and ack
  frame_assembler u_asm (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .sym      (sym),
    .busy     (busy),
    .consume  (consume),
    .sl_ack   (sl_ack),
    .beat     (beat)
  );

  // valid/ready port
  packet_out_reg u_out (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .beat     (beat),
    .pkt_rdy  (pkt_rdy),
    .busy     (busy),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld)
  );

endmodule

//--- rtl/packet_out_reg.sv
// packet output register
`timescale 1ns/1ps

module packet_out_reg import pkt_pkg::*; (
  input  logic      CLK_IN,
  input  logic      RESET_IN,
  input  pkt_beat_t beat,      // new packet strobe and data
  input  logic      pkt_rdy,   // consumer takes packet
  output logic      busy,      // no room for another beat
  output pkt_data_t pkt_data,
  output logic      pkt_vld
);

  logic      full;    // holds a packet
  pkt_data_t data_q;

  // ------------------------------
  // occupancy
  // ------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      full <= 1'b0;
    end else if (beat.vld) begin
      full <= 1'b1;   // new packet, old one left this edge
    end else if (pkt_rdy) begin
      full <= 1'b0;   // taken, nothing behind it
    end
  end

  // payload, only written when the assembler saw busy low
  always_ff @(posedge CLK_IN) begin
    if (beat.vld) begin
      data_q <= beat.data;
    end
  end

  assign pkt_data = data_q;
  assign pkt_vld  = full;
  assign busy     = full && !pkt_rdy;  // free if it leaves this cycle

endmodule

//--- rtl/frame_assembler.sv
// link receive state machine
// ack generation and packet assembly
`timescale 1ns/1ps

module frame_assembler import link_pkg::*, pkt_pkg::*; (
  input  logic      CLK_IN,
  input  logic      RESET_IN,
  input  sym_t      sym,      // symbol on the wires right now
  input  logic      busy,     // output register cannot take a beat
  output logic      consume,  // ack decision, decoder takes wires
  output logic      sl_ack,   // link ack, toggles per symbol
  output pkt_beat_t beat      // finished packet
);

  localparam int CNT_W = $clog2(LONG_SYMS + 1);  // room for a full long frame

  typedef enum logic [1:0] {
    ST_REST,  // one cycle after reset, sends the initial ack
    ST_IDLE,  // between packets
    ST_TRAN,  // inside a frame
    ST_ERR    // dropping until eop
  } state_e;

  state_e          state;
  state_e          state_nxt;
  logic            is_dat;
  logic            is_eop;
  logic            is_oob;
  logic            exp_eop;    // frame has its full symbol count
  logic            long_pkt;   // from bit 1 of first symbol
  logic [CNT_W-1:0] sym_cnt;   // data symbols in this frame
  logic            ack_pend;   // consume seen last cycle
  pkt_data_t       pkt_buf;    // newest symbol on top

  assign is_dat = (sym.kind == SYM_DATA);
  assign is_eop = (sym.kind == SYM_EOP);
  assign is_oob = (sym.kind == SYM_OOB);

  assign exp_eop = long_pkt ? (sym_cnt == CNT_W'(LONG_SYMS))
                            : (sym_cnt == CNT_W'(SHORT_SYMS));

  // ------------------------------
  // control
  // ------------------------------
  always_comb begin
    state_nxt = state;
    consume   = 1'b0;
    case (state)
      ST_REST: begin
        consume   = 1'b1;  // latch wires, ack once like the chip does
        state_nxt = ST_IDLE;
      end
      ST_IDLE: begin
        consume = (sym.kind != SYM_NONE);
        if (is_dat) begin
          state_nxt = ST_TRAN;  // first symbol of a frame
        end else if (is_oob) begin
          state_nxt = ST_ERR;
        end
      end
      ST_TRAN: begin
        if (is_dat) begin
          consume = 1'b1;
        end else if (is_oob) begin
          consume   = 1'b1;
          state_nxt = ST_ERR;  // frame is lost
        end else if (is_eop && !exp_eop) begin
          consume   = 1'b1;    // framing error, drop
          state_nxt = ST_IDLE;
        end else if (is_eop && !busy) begin
          consume   = 1'b1;    // good frame, hand over
          state_nxt = ST_IDLE;
        end
        // expected eop while busy is held off, no ack
      end
      ST_ERR: begin
        consume = (sym.kind != SYM_NONE);  // ack and discard
        if (is_eop) begin
          state_nxt = ST_IDLE;
        end
      end
      default: begin
        state_nxt = ST_REST;
      end
    endcase
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= ST_REST;
    end else begin
      state <= state_nxt;
    end
  end

  // ack toggles the cycle after the decision
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      ack_pend <= 1'b0;
      sl_ack   <= 1'b0;
    end else begin
      ack_pend <= consume;
      if (ack_pend) begin
        sl_ack <= ~sl_ack;
      end
    end
  end

  // ------------------------------
  // frame tracking
  // ------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      sym_cnt  <= '0;
      long_pkt <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (is_dat) begin
            sym_cnt  <= CNT_W'(1);     // first symbol counts
            long_pkt <= sym.value[1];  // size flag
          end else begin
            sym_cnt <= '0;
          end
        end
        ST_TRAN: begin
          if (is_dat) begin
            sym_cnt <= sym_cnt + 1'b1;
          end
        end
        default: begin
          sym_cnt <= '0;
        end
      endcase
    end
  end

  // shift in from the top, first symbol ends up lowest
  always_ff @(posedge CLK_IN) begin
    if (is_dat && (state == ST_IDLE || state == ST_TRAN)) begin
      pkt_buf <= {sym.value, pkt_buf[PKT_BITS-1:$bits(nibble_t)]};
    end
  end

  // ------------------------------
  // beat to output register
  // ------------------------------
  assign beat.vld = (state == ST_TRAN) && is_eop && exp_eop && !busy;

  always_comb begin
    if (long_pkt) begin
      beat.data = pkt_buf;
    end else begin
      // short frame only filled the top bits
      beat.data = {{(PKT_BITS - SHORT_BITS){1'b0}},
                   pkt_buf[PKT_BITS-SHORT_BITS +: SHORT_BITS]};
    end
  end

endmodule

//--- rtl/symbol_decoder.sv
// 2-of-7 symbol decoder
`timescale 1ns/1ps

module symbol_decoder import link_pkg::*; (
  input  logic  CLK_IN,
  input  logic  RESET_IN,
  input  code_t wires,    // present link wires
  input  logic  consume,  // take present wires as new reference
  output sym_t  sym       // decoded transition
);

  code_t old_wires;  // wire state at last consumed symbol
  code_t diff;       // wires that changed since then

  // ------------------------------
  // reference wire state
  // ------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      old_wires <= '0;
    end else if (consume) begin
      old_wires <= wires;  // symbol taken, new baseline
    end
  end

  assign diff = wires ^ old_wires;

  // ------------------------------
  // transition classification
  // ------------------------------
  always_comb begin
    sym.kind  = SYM_DATA;  // most patterns below are data
    sym.value = 4'h0;
    if ($onehot0(diff)) begin
      sym.kind = SYM_NONE;  // nothing yet, or half a symbol
    end else begin
      case (diff)
        // one wire of 6..4 with one of 3..0
        7'b001_0001: sym.value = 4'd0;
        7'b001_0010: sym.value = 4'd1;
        7'b001_0100: sym.value = 4'd2;
        7'b001_1000: sym.value = 4'd3;
        7'b010_0001: sym.value = 4'd4;
        7'b010_0010: sym.value = 4'd5;
        7'b010_0100: sym.value = 4'd6;
        7'b010_1000: sym.value = 4'd7;
        7'b100_0001: sym.value = 4'd8;
        7'b100_0010: sym.value = 4'd9;
        7'b100_0100: sym.value = 4'd10;
        7'b100_1000: sym.value = 4'd11;
        // adjacent pairs within 3..0
        7'b000_0011: sym.value = 4'd12;
        7'b000_0110: sym.value = 4'd13;
        7'b000_1100: sym.value = 4'd14;
        7'b000_1001: sym.value = 4'd15;
        EOP_CODE: begin
          sym.kind = SYM_EOP;
        end
        default: begin
          sym.kind = SYM_OOB;  // three or more wires, or an unused pair
        end
      endcase
    end
  end

endmodule

//--- rtl/pkt_pkg.sv
// packet port definitions
package pkt_pkg;

  // ------------------------------
  // packet sizes
  // ------------------------------
  localparam int PKT_BITS   = 72;  // widest packet, port width
  localparam int SHORT_BITS = 40;  // short packet payload

  // symbols per frame, eop not counted
  localparam int SHORT_SYMS = 10;
  localparam int LONG_SYMS  = 18;

  // ------------------------------
  // packet types
  // ------------------------------
  // symbol i sits at bits 4i+3..4i
  typedef logic [PKT_BITS-1:0] pkt_data_t;

  // assembler to output register
  typedef struct packed {
    logic      vld;   // one-cycle strobe
    pkt_data_t data;  // short packets zero padded on top
  } pkt_beat_t;

endpackage

//--- rtl/link_pkg.sv
// spinnaker link code
// 2-of-7 nrz symbol types
package link_pkg;

  // ------------------------------
  // wire level types
  // ------------------------------
  // one bit per link wire, also used for the xor of two wire states
  typedef logic [6:0] code_t;

  // data carried by one symbol
  typedef logic [3:0] nibble_t;

  // ------------------------------
  // symbol classes
  // ------------------------------
  typedef enum logic [1:0] {
    SYM_NONE = 2'd0,  // no change or only one wire flipped so far
    SYM_DATA = 2'd1,  // one of the 16 nibble codes
    SYM_EOP  = 2'd2,  // end of packet
    SYM_OOB  = 2'd3   // anything else, out of band
  } sym_kind_e;

  // one decoded symbol
  typedef struct packed {
    sym_kind_e kind;
    nibble_t   value;  // valid for SYM_DATA only, zero otherwise
  } sym_t;

  // end-of-packet transition, wires 6 and 5
  localparam code_t EOP_CODE = 7'b110_0000;

  // data codes use one wire of 6..4 and one of 3..0,
  // except 12..15 which pair up wires of 3..0
  // (table is kept in the decoder)

endpackage
